/* files.f */
source/pg_format_pkg.sv
source/pg_table_pkg.sv
source/pg_fnum_path.sv
source/pg_detune_path.sv
source/pg_phase_accum.sv
source/pg_top.sv
tb/tb_pg_top.sv

/* tb/tb_pg_top.sv */
`timescale 1ns/1ps

module tb_pg_top
    import pg_format_pkg::*, pg_table_pkg::*;
();

    localparam int phase_slots  = 32;
    localparam int reset_cycles = 8;
    localparam int fill_limit   = 400;

    logic       i_EMUCLK;
    logic       i_rst;
    logic [6:0] i_kc;
    logic [5:0] i_kf;
    logic [2:0] i_dt1;
    logic [3:0] i_mul;
    logic       i_phase_rst;
    logic [9:0] o_phase;
    logic [4:0] o_eg_shift;

    // reference model state
    logic [31:0]        rng_state;
    logic [phase_w-1:0] slot_phase [0:phase_slots-1];
    logic [phase_w-1:0] pend_prod [$];
    logic               pend_rst [$];
    logic [4:0]         pend_eg [$];
    int                 edge_cnt;
    int                 check_count;
    int                 error_count;
    logic               filled;

    pg_top #(
        .phase_slots (phase_slots)
    ) UUT (
        .i_EMUCLK    (i_EMUCLK),
        .i_rst       (i_rst),
        .i_kc        (i_kc),
        .i_kf        (i_kf),
        .i_dt1       (i_dt1),
        .i_mul       (i_mul),
        .i_phase_rst (i_phase_rst),
        .o_phase     (o_phase),
        .o_eg_shift  (o_eg_shift)
    );

    initial begin
        i_EMUCLK = 1'b0;
        forever #4 i_EMUCLK = ~i_EMUCLK;
    end

    //////////////////////////////
    // reference arithmetic
    //////////////////////////////

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [pdelta_w-1:0] fnum_increment(input logic [6:0] kc,
                                                           input logic [5:0] kf);
        logic [5:0]             note;
        logic [fnum_base_w-1:0] base;
        inc_word_u              word;
        int                     lead;
        int                     inc;
        int                     fnum;
        int                     octave;
        note = {kc[3:0], kf[5:4]};
        base = fnum_base_lookup(note);
        word = fnum_inc_lookup(note);
        inc  = 0;
        if (word.m1.calcmode) begin
            lead = 16 + word.m1.mcand;
            for (int j = 0; j < 4; j++) begin
                if (kf[j]) begin
                    inc += lead >> (3 - j);
                end
            end
        end else begin
            // odd lead, quarter term replaced by fixed corrections
            lead = 17 + 2 * word.m0.mcand;
            if (kf[3]) begin
                inc += lead + 1;
            end
            if (kf[2]) begin
                inc += lead >> 1;
            end
            if (kf[1]) begin
                inc += 8;
            end
            if (kf[0]) begin
                inc += (lead >> 3) + 2;
            end
            if (kf[3] && kf[2] && !word.m0.no_plus4) begin
                inc += 4;
            end
        end
        fnum   = (base + (inc >> 1)) % 4096;
        octave = kc[6:4];
        if (octave < 2) begin
            fnum = fnum >> (2 - octave);
        end else begin
            fnum = fnum << (octave - 2);
        end
        return pdelta_w'(fnum);
    endfunction

    function automatic logic [pdelta_w-1:0] detune_amount(input logic [6:0] kc,
                                                          input logic [2:0] dt1);
        int         intensity;
        int         sel;
        int         k;
        int         mag;
        logic [4:0] base;
        intensity = kc[6:4] + dt1_intensity_offset(dt1[1:0]) + 1;
        sel  = (kc[6:2] >= 5'd28) ? 0 : kc[3:2];
        base = dt1_base_lookup(intensity[0], 2'(sel));
        k    = intensity / 2;
        mag  = 0;
        if (dt1[1:0] != 2'b00 && k >= 5 && k <= 9) begin
            mag = base >> (9 - k);
        end
        return dt1[2] ? pdelta_w'(-mag) : pdelta_w'(mag);
    endfunction

    function automatic logic [phase_w-1:0] apply_multiple(input logic [pdelta_w-1:0] sum,
                                                          input logic [3:0] mul);
        int prod;
        prod = sum * mul;
        if (mul == 4'd0) begin
            return phase_w'(sum >> 1);
        end
        return phase_w'(prod);
    endfunction

    //////////////////////////////
    // stimulus and checks
    //////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED at time %0t: %s got %0h expected %0h",
                     $time, what, got, expected);
        end
    endtask

    // mode 0 plain pitch, 1 adds dt1, 2 adds mul, 3 adds random phase reset
    // mode 4 holds phase reset on every slot
    task automatic drive_slot(input int mode);
        logic [31:0]         r1;
        logic [31:0]         r2;
        logic [2:0]          dt1;
        logic [3:0]          mul;
        logic                prst;
        logic [pdelta_w-1:0] sum;
        r1   = lcg_next();
        r2   = lcg_next();
        dt1  = (mode == 0) ? 3'd0 : r2[31:29];
        mul  = (mode < 2) ? 4'd1 : r2[27:24];
        prst = (mode == 4) || (mode == 3 && r2[22:20] == 3'd0);
        i_kc        <= r1[30:24];
        i_kf        <= r1[21:16];
        i_dt1       <= dt1;
        i_mul       <= mul;
        i_phase_rst <= prst;
        // carry out of the detuned sum is dropped
        sum = fnum_increment(r1[30:24], r1[21:16]) + detune_amount(r1[30:24], dt1);
        pend_prod.push_back(apply_multiple(sum, mul));
        pend_rst.push_back(prst);
        pend_eg.push_back(r1[30:26]);
    endtask

    task automatic step_cycle(input int mode);
        logic [phase_w-1:0] prod;
        logic               prst;
        logic [phase_w-1:0] exp_phase;
        logic [4:0]         exp_eg;
        int                 slot;
        @(posedge i_EMUCLK);
        edge_cnt++;
        drive_slot(mode);
        slot      = edge_cnt % phase_slots;
        exp_phase = '0;
        exp_eg    = '0;
        // phase lags the sampled settings by six edges, eg shift by three
        if (edge_cnt >= 7) begin
            prod = pend_prod.pop_front();
            prst = pend_rst.pop_front();
            exp_phase = prst ? '0 : slot_phase[slot] + prod;
        end
        slot_phase[slot] = exp_phase;
        if (edge_cnt >= 4) begin
            exp_eg = pend_eg.pop_front();
        end
        @(negedge i_EMUCLK);
        check_value("o_phase", o_phase, exp_phase[phase_w-1:phase_w-out_phase_w]);
        check_value("o_eg_shift", o_eg_shift, exp_eg);
    endtask

    task automatic run_cycles(input int count, input int mode);
        for (int i = 0; i < count; i++) begin
            step_cycle(mode);
        end
    endtask

    task automatic wait_for_output(output logic ok);
        int cnt;
        ok  = 1'b0;
        cnt = 0;
        while (!ok && cnt < fill_limit) begin
            step_cycle(0);
            cnt++;
            ok = (o_phase != '0);
        end
    endtask

    initial begin
        rng_state   = 32'heed8_58b7;
        edge_cnt    = 0;
        check_count = 0;
        error_count = 0;
        filled      = 1'b0;
        for (int i = 0; i < phase_slots; i++) begin
            slot_phase[i] = '0;
        end
        i_rst       <= 1'b1;
        i_kc        <= '0;
        i_kf        <= '0;
        i_dt1       <= '0;
        i_mul       <= '0;
        i_phase_rst <= 1'b0;

        // first live settings go out on the edge that releases reset
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge i_EMUCLK);
            if (i == reset_cycles - 1) begin
                i_rst <= 1'b0;
                drive_slot(0);
            end
            @(negedge i_EMUCLK);
            check_value("o_phase in reset", o_phase, 0);
            check_value("o_eg_shift in reset", o_eg_shift, 0);
        end

        wait_for_output(filled);
        if (filled) begin
            run_cycles(150, 0);
            run_cycles(250, 1);
            run_cycles(300, 2);
            run_cycles(400, 3);
            run_cycles(40, 4);
            run_cycles(100, 2);
        end else begin
            error_count++;
            $display("timeout: o_phase stayed zero for %0d cycles after reset", fill_limit);
        end

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* source/pg_top.sv */
`timescale 1ns/1ps

module pg_top #(
    parameter int phase_slots = 32
) (
    input  logic       i_EMUCLK,
    input  logic       i_rst,
    input  logic [6:0] i_kc,
    input  logic [5:0] i_kf,
    input  logic [2:0] i_dt1,
    input  logic [3:0] i_mul,
    input  logic       i_phase_rst,
    output logic [9:0] o_phase,
    output logic [4:0] o_eg_shift
);

    logic [16:0] shifted_pdelta;
    logic [16:0] detune_value;
    logic [3:0]  mul_d;

    // f-number and detune run side by side, both 4 cycles deep
    pg_fnum_path u_fnum_path (
        .i_EMUCLK         (i_EMUCLK),
        .i_rst            (i_rst),
        .i_kc             (i_kc),
        .i_kf             (i_kf),
        .o_shifted_pdelta (shifted_pdelta)
    );

    pg_detune_path u_detune_path (
        .i_EMUCLK       (i_EMUCLK),
        .i_rst          (i_rst),
        .i_kc           (i_kc),
        .i_dt1          (i_dt1),
        .i_mul          (i_mul),
        .o_detune_value (detune_value),
        .o_mul          (mul_d),
        .o_eg_shift     (o_eg_shift)
    );

    pg_phase_accum #(
        .phase_slots (phase_slots)
    ) u_phase_accum (
        .i_EMUCLK         (i_EMUCLK),
        .i_rst            (i_rst),
        .i_shifted_pdelta (shifted_pdelta),
        .i_detune_value   (detune_value),
        .i_mul            (mul_d),
        .i_phase_rst      (i_phase_rst),
        .o_phase          (o_phase)
    );

endmodule

/* source/pg_phase_accum.sv */
`timescale 1ns/1ps

module pg_phase_accum
    import pg_format_pkg::*;
#(
    parameter int phase_slots = 32
) (
    input  logic                   i_EMUCLK,
    input  logic                   i_rst,
    input  logic [pdelta_w-1:0]    i_shifted_pdelta,
    input  logic [pdelta_w-1:0]    i_detune_value,
    input  logic [3:0]             i_mul,
    input  logic                   i_phase_rst,
    output logic [out_phase_w-1:0] o_phase
);

    // phase_rst arrives with the slot settings four cycles ahead of the increment
    logic [3:0]             rst_align;
    logic                   rst_s1, rst_s2;

    logic [pdelta_w-1:0]    sum_s1;
    logic [3:0]             mul_s1;
    logic [pdelta_w+3:0]    prod_full;
    logic [phase_w-1:0]     prod_s2;
    logic [phase_w-1:0]     phase_q;
    logic [phase_w-1:0]     ring [0:phase_slots-2];

    assign prod_full = {4'b0, sum_s1} * {{pdelta_w{1'b0}}, mul_s1};

    //////////////////////////////
    // detune, multiple, add
    //////////////////////////////

    always_ff @(posedge i_EMUCLK) begin
        if (i_rst) begin
            rst_align <= '0;
            rst_s1    <= 1'b0;
            rst_s2    <= 1'b0;
            sum_s1    <= '0;
            mul_s1    <= '0;
            prod_s2   <= '0;
            phase_q   <= '0;
        end else begin
            rst_align <= {rst_align[2:0], i_phase_rst};
            rst_s1    <= rst_align[3];
            rst_s2    <= rst_s1;

            // carry out is dropped
            sum_s1 <= i_shifted_pdelta + i_detune_value;
            mul_s1 <= i_mul;

            // mul 0 means half
            if (mul_s1 == 4'd0) begin
                prod_s2 <= phase_w'(sum_s1 >> 1);
            end else begin
                prod_s2 <= prod_full[phase_w-1:0];
            end

            if (rst_s2) begin
                phase_q <= '0;
            end else begin
                phase_q <= ring[phase_slots-2] + prod_s2;
            end
        end
    end

    //////////////////////////////
    // slot ring
    //////////////////////////////

    always_ff @(posedge i_EMUCLK) begin
        if (i_rst) begin
            for (int i = 0; i < phase_slots - 1; i++) begin
                ring[i] <= '0;
            end
        end else begin
            ring[0] <= phase_q;
            for (int i = 1; i < phase_slots - 1; i++) begin
                ring[i] <= ring[i-1];
            end
        end
    end

    assign o_phase = phase_q[phase_w-1:phase_w-out_phase_w]; 

    // first phase after reset adds a cleared ring entry and a cleared product
    a_reset_clears_phase: assert property (@(posedge i_EMUCLK)
        $fell(i_rst) |=> (o_phase == '0));

endmodule

/* source/pg_detune_path.sv */
`timescale 1ns/1ps

module pg_detune_path
    import pg_format_pkg::*, pg_table_pkg::*;
(
    input  logic                i_EMUCLK,
    input  logic                i_rst,
    input  logic [6:0]          i_kc,
    input  logic [2:0]          i_dt1,
    input  logic [3:0]          i_mul,
    output logic [pdelta_w-1:0] o_detune_value,
    output logic [3:0]          o_mul,
    output logic [4:0]          o_eg_shift
);

    logic [4:0] shift_s1, shift_s2, shift_s3;
    logic [2:0] dt1_s1;
    logic [3:0] mul_s1, mul_s2, mul_s3;

    logic [4:0] intensity;
    logic [1:0] base_sel;
    logic [4:0] intensity_s2;
    logic [4:0] base_s2;
    logic       neg_s2, neg_s3;
    logic       zero_s2;
    logic [4:0] mag_s3;
    logic [pdelta_w-1:0] mag_ext;

    // top octaves fall back to the first selector
    assign intensity = {2'b00, shift_s1[4:2]} + {1'b0, dt1_intensity_offset(dt1_s1[1:0])} + 5'd1;
    assign base_sel  = (shift_s1 >= 5'd28) ? 2'd0 : shift_s1[1:0];
    assign mag_ext   = {{(pdelta_w-5){1'b0}}, mag_s3};

    //////////////////////////////
    // dt1 pipeline
    //////////////////////////////

    always_ff @(posedge i_EMUCLK) begin
        if (i_rst) begin
            shift_s1       <= '0;
            dt1_s1         <= '0;
            mul_s1         <= '0;
            intensity_s2   <= '0;
            base_s2        <= '0;
            neg_s2         <= 1'b0;
            zero_s2        <= 1'b0;
            shift_s2       <= '0;
            mul_s2         <= '0;
            mag_s3         <= '0;
            neg_s3         <= 1'b0;
            shift_s3       <= '0;
            mul_s3         <= '0;
            o_detune_value <= '0;
            o_eg_shift     <= '0;
            o_mul          <= '0;
        end else begin
            shift_s1 <= i_kc[6:2];
            dt1_s1   <= i_dt1;
            mul_s1   <= i_mul;

            intensity_s2 <= intensity;
            base_s2      <= dt1_base_lookup(intensity[0], base_sel);
            neg_s2       <= dt1_s1[2];
            zero_s2      <= (dt1_s1[1:0] == 2'b00);
            shift_s2     <= shift_s1;
            mul_s2       <= mul_s1;

            // keep more base bits as intensity rises
            if (zero_s2) begin
                mag_s3 <= '0;
            end else begin
                case (intensity_s2[4:1])
                    4'd5: mag_s3 <= {4'b0, base_s2[4]};
                    4'd6: mag_s3 <= {3'b0, base_s2[4:3]};
                    4'd7: mag_s3 <= {2'b0, base_s2[4:2]};
                    4'd8: mag_s3 <= {1'b0, base_s2[4:1]};
                    4'd9: mag_s3 <= base_s2;
                    default: mag_s3 <= '0;
                endcase
            end
            neg_s3   <= neg_s2;
            shift_s3 <= shift_s2;
            mul_s3   <= mul_s2;

            o_detune_value <= neg_s3 ? (~mag_ext + 1'b1) : mag_ext;
            o_eg_shift     <= shift_s3;
            o_mul          <= mul_s3;
        end
    end

    a_dt1_off_no_detune: assert property (@(posedge i_EMUCLK) disable iff (i_rst)
        (dt1_s1[1:0] == 2'b00) |-> ##3 (o_detune_value == '0));

endmodule

/* source/pg_fnum_path.sv */
`timescale 1ns/1ps

module pg_fnum_path
    import pg_format_pkg::*, pg_table_pkg::*;
(
    input  logic                i_EMUCLK,
    input  logic                i_rst,
    input  logic [6:0]          i_kc,
    input  logic [5:0]          i_kf,
    output logic [pdelta_w-1:0] o_shifted_pdelta
);

    // without vibrato the pitch word is just kc:kf
    logic [pitch_w-1:0]     pitch;

    logic [fnum_base_w-1:0] base_s1;
    inc_word_u              inc_s1;
    logic [3:0]             mult_s1;
    logic [4:0]             shift_s1;

    logic [4:0]             lead;
    logic [6:0]             inc_sum;
    logic [fnum_base_w-1:0] base_s2;
    logic [6:0]             inc_s2;
    logic [4:0]             shift_s2;

    logic [fnum_base_w-1:0] fnum_s3;
    logic [4:0]             shift_s3;

    assign pitch = {i_kc, i_kf};

    //////////////////////////////
    // stage 1 and 2
    //////////////////////////////

    // decompress the fine increment word
    always_comb begin
        if (inc_s1.m1.calcmode) begin
            lead = {1'b1, inc_s1.m1.mcand};
            inc_sum = 7'(lead & {5{mult_s1[3]}})
                    + 7'((lead >> 1) & {5{mult_s1[2]}})
                    + 7'((lead >> 2) & {5{mult_s1[1]}})
                    + 7'((lead >> 3) & {5{mult_s1[0]}});
        end else begin
            lead = {1'b1, inc_s1.m0.mcand, 1'b1};
            inc_sum = 7'(lead & {5{mult_s1[3]}})
                    + 7'((lead >> 1) & {5{mult_s1[2]}})
                    + 7'((lead >> 3) & {5{mult_s1[0]}})
                    + ((&mult_s1[3:2] && !inc_s1.m0.no_plus4) ? 7'd4 : 7'd0)
                    + (mult_s1[3] ? 7'd1 : 7'd0)
                    + (mult_s1[1] ? 7'd8 : 7'd0)
                    + (mult_s1[0] ? 7'd2 : 7'd0);
        end
    end

    always_ff @(posedge i_EMUCLK) begin
        if (i_rst) begin
            base_s1  <= '0;
            inc_s1   <= '0;
            mult_s1  <= '0;
            shift_s1 <= '0;
            base_s2  <= '0;
            inc_s2   <= '0;
            shift_s2 <= '0;
        end else begin
            base_s1  <= fnum_base_lookup(pitch[9:4]);
            inc_s1   <= fnum_inc_lookup(pitch[9:4]);
            mult_s1  <= pitch[3:0];
            shift_s1 <= pitch[12:8];
            base_s2  <= base_s1;
            inc_s2   <= inc_sum;
            shift_s2 <= shift_s1;
        end
    end

    //////////////////////////////
    // stage 3 and 4
    //////////////////////////////

    always_ff @(posedge i_EMUCLK) begin
        if (i_rst) begin
            fnum_s3          <= '0;
            shift_s3         <= '0;
            o_shifted_pdelta <= '0;
        end else begin
            // lsb of the increment is dropped
            fnum_s3  <= base_s2 + {6'b0, inc_s2[6:1]};
            shift_s3 <= shift_s2;
            // octave 0 goes right by two and octave 7 left by five
            case (shift_s3[4:2])
                3'd0: o_shifted_pdelta <= {7'b0, fnum_s3[11:2]};
                3'd1: o_shifted_pdelta <= {6'b0, fnum_s3[11:1]};
                3'd2: o_shifted_pdelta <= {5'b0, fnum_s3};
                3'd3: o_shifted_pdelta <= {4'b0, fnum_s3, 1'b0};
                3'd4: o_shifted_pdelta <= {3'b0, fnum_s3, 2'b0};
                3'd5: o_shifted_pdelta <= {2'b0, fnum_s3, 3'b0};
                3'd6: o_shifted_pdelta <= {1'b0, fnum_s3, 4'b0};
                default: o_shifted_pdelta <= {fnum_s3, 5'b0};
            endcase
        end
    end

    // note codes 3, 7, 11, 15 are holes in the table
    a_note_hole_zero: assert property (@(posedge i_EMUCLK) disable iff (i_rst)
        (i_kc[1:0] == 2'd3) |=> (base_s1 == '0));

endmodule

/* source/pg_table_pkg.sv */
package pg_table_pkg;
    import pg_format_pkg::*;

    //////////////////////////////
    // note to f-number rom
    //////////////////////////////

    // packed as {base, increment word} with unused notes reading zero
    function automatic logic [fnum_base_w+4:0] fnum_rom(input logic [5:0] idx);
        case (idx)
            6'h00: fnum_rom = {12'b010100_010011, 5'b00111};
            6'h01: fnum_rom = {12'b010100_100110, 5'b00111};
            6'h02: fnum_rom = {12'b010100_111001, 5'b00111};
            6'h03: fnum_rom = {12'b010101_001100, 5'b01001};
            6'h04: fnum_rom = {12'b010101_100000, 5'b01001};
            6'h05: fnum_rom = {12'b010101_110100, 5'b01001};
            6'h06: fnum_rom = {12'b010110_001000, 5'b01011};
            6'h07: fnum_rom = {12'b010110_011101, 5'b01001};
            6'h08: fnum_rom = {12'b010110_110010, 5'b01011};
            6'h09: fnum_rom = {12'b010111_000111, 5'b01011};
            6'h0A: fnum_rom = {12'b010111_011101, 5'b01101};
            6'h0B: fnum_rom = {12'b010111_110011, 5'b01101};
            6'h10: fnum_rom = {12'b011000_001001, 5'b01101};
            6'h11: fnum_rom = {12'b011000_011111, 5'b01101};
            6'h12: fnum_rom = {12'b011000_110110, 5'b01111};
            6'h13: fnum_rom = {12'b011001_001101, 5'b01111};
            6'h14: fnum_rom = {12'b011001_100101, 5'b01111};
            6'h15: fnum_rom = {12'b011001_111100, 5'b10001};
            6'h16: fnum_rom = {12'b011010_010101, 5'b10001};
            6'h17: fnum_rom = {12'b011010_101101, 5'b10001};
            6'h18: fnum_rom = {12'b011011_000110, 5'b10011};
            6'h19: fnum_rom = {12'b011011_011111, 5'b10011};
            6'h1A: fnum_rom = {12'b011011_111001, 5'b10101};
            6'h1B: fnum_rom = {12'b011100_010011, 5'b10101};
            6'h20: fnum_rom = {12'b011100_101101, 5'b10101};
            6'h21: fnum_rom = {12'b011101_001000, 5'b10111};
            6'h22: fnum_rom = {12'b011101_100011, 5'b10111};
            6'h23: fnum_rom = {12'b011101_111110, 5'b11001};
            6'h24: fnum_rom = {12'b011110_011010, 5'b11001};
            6'h25: fnum_rom = {12'b011110_110111, 5'b11001};
            6'h26: fnum_rom = {12'b011111_010011, 5'b11011};
            6'h27: fnum_rom = {12'b011111_110000, 5'b11101};
            6'h28: fnum_rom = {12'b100000_001110, 5'b11101};
            6'h29: fnum_rom = {12'b100000_101100, 5'b11101};
            6'h2A: fnum_rom = {12'b100001_001010, 5'b11111};
            6'h2B: fnum_rom = {12'b100001_101001, 5'b11111};
            6'h30: fnum_rom = {12'b100010_001001, 5'b11111};
            6'h31: fnum_rom = {12'b100010_101000, 5'b11110};
            6'h32: fnum_rom = {12'b100011_001001, 5'b11110};
            6'h33: fnum_rom = {12'b100011_101001, 5'b11110};
            6'h34: fnum_rom = {12'b100100_001011, 5'b11110};
            6'h35: fnum_rom = {12'b100100_101100, 5'b11110};
            6'h36: fnum_rom = {12'b100101_001110, 5'b11100};
            6'h37: fnum_rom = {12'b100101_110001, 5'b11100};
            6'h38: fnum_rom = {12'b100110_010100, 5'b11100};
            6'h39: fnum_rom = {12'b100110_111000, 5'b11100};
            6'h3A: fnum_rom = {12'b100111_011100, 5'b11100};
            6'h3B: fnum_rom = {12'b101000_000001, 5'b11100};
            default: fnum_rom = '0;
        endcase
    endfunction

    function automatic logic [fnum_base_w-1:0] fnum_base_lookup(input logic [5:0] idx);
        logic [fnum_base_w+4:0] entry;
        entry = fnum_rom(idx);
        fnum_base_lookup = entry[fnum_base_w+4:5];
    endfunction

    function automatic inc_word_u fnum_inc_lookup(input logic [5:0] idx);
        logic [fnum_base_w+4:0] entry;
        entry = fnum_rom(idx);
        fnum_inc_lookup = entry[4:0];
    endfunction

    //////////////////////////////
    // dt1 constants
    //////////////////////////////

    function automatic logic [3:0] dt1_intensity_offset(input logic [1:0] dt1_lo);
        case (dt1_lo)
            2'd0: dt1_intensity_offset = 4'd0;
            2'd1: dt1_intensity_offset = 4'd8;
            2'd2: dt1_intensity_offset = 4'd10;
            default: dt1_intensity_offset = 4'd11;
        endcase
    endfunction

    // even intensities use the lower row and odd ones the upper
    function automatic logic [4:0] dt1_base_lookup(input logic odd, input logic [1:0] sel);
        case ({odd, sel})
            3'b0_00: dt1_base_lookup = 5'b10000;
            3'b0_01: dt1_base_lookup = 5'b10001;
            3'b0_10: dt1_base_lookup = 5'b10011;
            3'b0_11: dt1_base_lookup = 5'b10100;
            3'b1_00: dt1_base_lookup = 5'b10110;
            3'b1_01: dt1_base_lookup = 5'b11000;
            3'b1_10: dt1_base_lookup = 5'b11011;
            default: dt1_base_lookup = 5'b11101;
        endcase
    endfunction

endpackage

/* source/pg_format_pkg.sv */
package pg_format_pkg;

    //////////////////////////////
    // word widths
    //////////////////////////////

    // key code (7) followed by key fraction (6)
    localparam int pitch_w     = 13;
    localparam int pdelta_w    = 17;
    localparam int phase_w     = 20;
    localparam int out_phase_w = 10;
    localparam int fnum_base_w = 12;

    //////////////////////////////
    // table increment word
    //////////////////////////////

    // calcmode 1: plain four bit multiplicand
    typedef struct packed {
        logic [3:0] mcand;
        logic       calcmode;
    } inc_mode1_t;

    // calcmode 0: three bit multiplicand plus the +4 suppress flag
    typedef struct packed {
        logic [2:0] mcand;
        logic       no_plus4;
        logic       calcmode;
    } inc_mode0_t;

    // calcmode sits in bit 0 of both views
    typedef union packed {
        inc_mode1_t m1;
        inc_mode0_t m0;
    } inc_word_u;

endpackage
